// File: rtl/seq_cpu_pkg.sv
package seq_cpu_pkg;

    localparam int data_w     = 8;
    localparam int reg_addr_w = 3;
    localparam int num_regs   = 8;
    localparam int max_loops  = 10;
    localparam int loop_cnt_w = 4;   // holds 0..max_loops

    localparam logic [reg_addr_w-1:0] cmp_hi_reg = 3'd7; // left side of a_gt_b
    localparam logic [reg_addr_w-1:0] cmp_lo_reg = 3'd3;

    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_xor = 3'd4,
        alu_not = 3'd5   // ~a, b unused
    } alu_op_e;

    typedef enum logic {src_alu = 1'b0, src_ext = 1'b1} wr_src_e;

    typedef enum logic {ext_a = 1'b0, ext_b = 1'b1} ext_sel_e;

    // one microinstruction, 16 bits
    typedef struct packed {
        wr_src_e               wr_src;
        ext_sel_e              ext_sel;
        logic [reg_addr_w-1:0] rd_addr1;
        logic [reg_addr_w-1:0] rd_addr2;
        logic [reg_addr_w-1:0] wr_addr;
        logic                  wr_en;
        logic                  out_en;
        alu_op_e               alu_op;
    } ctrl_word_t;

    typedef struct packed {
        logic a_gt_b;
    } dp_flags_t;

    typedef enum logic [3:0] {
        st_idle, st_load1, st_clear2, st_load3, st_init4, st_add5, st_sub6,
        st_and2, st_or3, st_xor7, st_not7, st_branch, st_done
    } state_e;

endpackage

// File: rtl/alu.sv
`timescale 1ns/1ns

module alu import seq_cpu_pkg::*; (
    input  alu_op_e           op,
    input  logic [data_w-1:0] a,
    input  logic [data_w-1:0] b,
    output logic [data_w-1:0] y
);

    always_comb begin
        case (op)
            alu_add: begin
                y = a + b;                  // wraps at data_w
            end
            alu_sub: begin
                y = a - b;
            end
            alu_and: begin
                y = a & b;
            end
            alu_or: begin
                y = a | b;
            end
            alu_xor: begin
                y = a ^ b;
            end
            alu_not: begin
                y = ~a;
            end
            default: begin
                y = '0;                     // unused codes
            end
        endcase
    end

endmodule

// File: rtl/register_file.sv
`timescale 1ns/1ns

module register_file import seq_cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  wr_en,
    input  logic [reg_addr_w-1:0] wr_addr,
    input  logic [data_w-1:0]     wr_data,
    input  logic [reg_addr_w-1:0] rd_addr1,
    input  logic [reg_addr_w-1:0] rd_addr2,
    output logic [data_w-1:0]     rd_data1,
    output logic [data_w-1:0]     rd_data2,
    output logic [data_w-1:0]     cmp_hi,
    output logic [data_w-1:0]     cmp_lo
);

    logic [data_w-1:0] regs [1:num_regs-1]; // r0 has no storage

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 1; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    always_comb begin
        rd_data1 = '0;
        rd_data2 = '0;
        if (rd_addr1 != '0) begin
            rd_data1 = regs[rd_addr1];
        end
        if (rd_addr2 != '0) begin
            rd_data2 = regs[rd_addr2];
        end
    end

    // fixed taps for the flag compare
    assign cmp_hi = regs[cmp_hi_reg];
    assign cmp_lo = regs[cmp_lo_reg];

endmodule

// File: rtl/control_unit.sv
`timescale 1ns/1ns

module control_unit import seq_cpu_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       start,
    input  dp_flags_t  flags,
    output ctrl_word_t ctrl,
    output logic       busy,
    output logic       done
);

    state_e                state;
    state_e                state_next;
    logic [loop_cnt_w-1:0] loop_cnt;
    logic [loop_cnt_w-1:0] loop_cnt_inc;
    logic                  go_on;

    // alu step that writes back and updates the output buffer
    function automatic ctrl_word_t alu_word(
        input alu_op_e               op,
        input logic [reg_addr_w-1:0] ra,
        input logic [reg_addr_w-1:0] rb,
        input logic [reg_addr_w-1:0] wa
    );
        ctrl_word_t w;
        w          = '0;
        w.wr_src   = src_alu;
        w.rd_addr1 = ra;
        w.rd_addr2 = rb;
        w.wr_addr  = wa;
        w.wr_en    = 1'b1;
        w.out_en   = 1'b1;
        w.alu_op   = op;
        return w;
    endfunction

    // register load from one of the external operands
    function automatic ctrl_word_t ext_word(
        input ext_sel_e              sel,
        input logic [reg_addr_w-1:0] wa
    );
        ctrl_word_t w;
        w         = '0;
        w.wr_src  = src_ext;
        w.ext_sel = sel;
        w.wr_addr = wa;
        w.wr_en   = 1'b1;
        return w;
    endfunction

    assign loop_cnt_inc = loop_cnt + 1'b1;
    assign go_on        = flags.a_gt_b && (loop_cnt_inc < loop_cnt_w'(max_loops));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= st_idle;
            loop_cnt <= '0;
        end else begin
            state <= state_next;
            if ((state == st_idle || state == st_done) && start) begin
                loop_cnt <= '0;             // fresh run
            end else if (state == st_branch) begin
                loop_cnt <= loop_cnt_inc;
            end
        end
    end

    always_comb begin
        state_next = state;
        ctrl       = '0;                    // idle word, no writes
        case (state)
            st_idle, st_done: begin
                if (start) begin
                    state_next = st_load1;
                end
            end
            st_load1: begin
                ctrl       = ext_word(ext_a, 3'd1);
                state_next = st_clear2;
            end
            st_clear2: begin
                ctrl        = alu_word(alu_add, 3'd0, 3'd0, 3'd2);
                ctrl.out_en = 1'b0;         // r2 = 0, buffer untouched
                state_next  = st_load3;
            end
            st_load3: begin
                ctrl       = ext_word(ext_b, 3'd3);
                state_next = st_init4;
            end
            st_init4: begin
                ctrl       = alu_word(alu_add, 3'd1, 3'd1, 3'd4);
                state_next = st_add5;
            end
            st_add5: begin
                ctrl       = alu_word(alu_add, 3'd4, 3'd4, 3'd5);
                state_next = st_sub6;
            end
            st_sub6: begin
                ctrl       = alu_word(alu_sub, 3'd5, 3'd1, 3'd6);
                state_next = st_and2;
            end
            st_and2: begin
                ctrl       = alu_word(alu_and, 3'd6, 3'd4, 3'd2);
                state_next = st_or3;
            end
            st_or3: begin
                ctrl       = alu_word(alu_or, 3'd2, 3'd5, 3'd3);
                state_next = st_xor7;
            end
            st_xor7: begin
                ctrl       = alu_word(alu_xor, 3'd3, 3'd2, 3'd7);
                state_next = st_not7;
            end
            st_not7: begin
                ctrl       = alu_word(alu_not, 3'd7, 3'd0, 3'd7);
                state_next = st_branch;
            end
            st_branch: begin
                state_next = go_on ? st_add5 : st_done;
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    assign busy = (state != st_idle) && (state != st_done);
    assign done = (state == st_done);

endmodule

// File: rtl/datapath.sv
`timescale 1ns/1ns

module datapath import seq_cpu_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  ctrl_word_t        ctrl,
    input  logic [data_w-1:0] data_a,
    input  logic [data_w-1:0] data_b,
    output dp_flags_t         flags,
    output logic [data_w-1:0] result
);

    logic [data_w-1:0] rd_data1;
    logic [data_w-1:0] rd_data2;
    logic [data_w-1:0] cmp_hi;
    logic [data_w-1:0] cmp_lo;
    logic [data_w-1:0] alu_y;
    logic [data_w-1:0] ext_data;
    logic [data_w-1:0] wr_data;

    assign ext_data = (ctrl.ext_sel == ext_b) ? data_b : data_a;
    assign wr_data  = (ctrl.wr_src == src_ext) ? ext_data : alu_y;

    register_file i_register_file (
        .clk      (clk),
        .reset    (reset),
        .wr_en    (ctrl.wr_en),
        .wr_addr  (ctrl.wr_addr),
        .wr_data  (wr_data),
        .rd_addr1 (ctrl.rd_addr1),
        .rd_addr2 (ctrl.rd_addr2),
        .rd_data1 (rd_data1),
        .rd_data2 (rd_data2),
        .cmp_hi   (cmp_hi),
        .cmp_lo   (cmp_lo)
    );

    alu i_alu (
        .op (ctrl.alu_op),
        .a  (rd_data1),
        .b  (rd_data2),
        .y  (alu_y)
    );

    // output buffer, follows every visible alu step
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            result <= '0;
        end else if (ctrl.out_en) begin
            result <= alu_y;
        end
    end

    // unsigned r7 > r3, straight from the register contents
    assign flags.a_gt_b = (cmp_hi > cmp_lo);

endmodule

// File: rtl/seq_cpu_top.sv
`timescale 1ns/1ns

module seq_cpu_top import seq_cpu_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    input  logic [data_w-1:0] data_a,
    input  logic [data_w-1:0] data_b,
    output logic [data_w-1:0] result,
    output logic              busy,
    output logic              done
);

    ctrl_word_t ctrl;
    dp_flags_t  flags;

    control_unit i_control_unit (
        .clk   (clk),
        .reset (reset),
        .start (start),
        .flags (flags),
        .ctrl  (ctrl),
        .busy  (busy),
        .done  (done)
    );

    datapath i_datapath (
        .clk    (clk),
        .reset  (reset),
        .ctrl   (ctrl),
        .data_a (data_a),
        .data_b (data_b),
        .flags  (flags),
        .result (result)
    );

endmodule

// File: bench/seq_cpu_model.svh
// runs the fixed microprogram on plain variables, data_w wrap throughout
task automatic seq_cpu_model(
    input  logic [data_w-1:0] a,
    input  logic [data_w-1:0] b,
    output logic [data_w-1:0] res,
    output int                passes
);
    logic [data_w-1:0] r1;
    logic [data_w-1:0] r2;
    logic [data_w-1:0] r3;
    logic [data_w-1:0] r4;
    logic [data_w-1:0] r5;
    logic [data_w-1:0] r6;
    logic [data_w-1:0] r7;
    logic [data_w-1:0] obuf;
    logic              gt;

    // prologue
    r1   = a;
    r2   = '0;                          // r0 + r0
    r3   = b;
    r4   = r1 + r1;
    obuf = r4;

    passes = 0;
    gt     = 1'b1;
    while (gt && passes < max_loops) begin
        r5   = r4 + r4;
        obuf = r5;
        r6   = r5 - r1;
        obuf = r6;
        r2   = r6 & r4;
        obuf = r2;
        r3   = r2 | r5;
        obuf = r3;
        r7   = r3 ^ r2;
        obuf = r7;
        r7   = ~r7;
        obuf = r7;
        passes++;                       // branch step
        gt = (r7 > r3);                 // unsigned compare
    end

    res = obuf;
endtask

// File: bench/tb_seq_cpu.sv
`timescale 1ns/1ns

module tb_seq_cpu import seq_cpu_pkg::*; ();

    localparam int num_runs     = 40;
    localparam int done_timeout = 200;

    logic              clk;
    logic              reset;
    logic              start;
    logic [data_w-1:0] data_a;
    logic [data_w-1:0] data_b;
    logic [data_w-1:0] result;
    logic              busy;
    logic              done;

    integer seed;

    seq_cpu_top i_seq_cpu_top (
        .clk    (clk),
        .reset  (reset),
        .start  (start),
        .data_a (data_a),
        .data_b (data_b),
        .result (result),
        .busy   (busy),
        .done   (done)
    );

    `include "seq_cpu_model.svh"

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;              // 8 ns period
        end
    end

    task automatic check_data(
        input logic [data_w-1:0] actual,
        input logic [data_w-1:0] expected,
        input string             name
    );
        if (actual !== expected) begin
            $display("ERROR %s: got 0x%h, expected 0x%h", name, actual, expected);
            $display("test failed");
            $fatal(1);
        end
    endtask

    task automatic check_flag(
        input logic  actual,
        input logic  expected,
        input string name
    );
        if (actual !== expected) begin
            $display("ERROR %s: got 0x%h, expected 0x%h", name, actual, expected);
            $display("test failed");
            $fatal(1);
        end
    endtask

    task automatic check_count(
        input int    actual,
        input int    expected,
        input string name
    );
        if (actual !== expected) begin
            $display("ERROR %s: got 0x%h, expected 0x%h", name, actual, expected);
            $display("test failed");
            $fatal(1);
        end
    endtask

    // one full run where poke adds a stray start strobe and junk operands mid-run
    task automatic run_once(
        input logic [data_w-1:0] a,
        input logic [data_w-1:0] b,
        input bit                poke
    );
        logic [data_w-1:0] exp_res;
        int                exp_passes;
        int                exp_cycles;
        int                cycles;

        seq_cpu_model(a, b, exp_res, exp_passes);
        // two loads, the clear and the init once, then seven states per pass
        exp_cycles = 3 + 1 + 7 * exp_passes;

        @(negedge clk);
        data_a = a;
        data_b = b;
        start  = 1'b1;
        @(negedge clk);
        start  = 1'b0;                  // now in st_load1

        cycles = 0;
        while (!done) begin
            check_flag(busy, 1'b1, "busy");
            check_flag(done, 1'b0, "done");
            // cycle 4 is st_add5, both operands already latched
            if (poke && cycles == 4) begin
                start  = 1'b1;
                data_a = ~a;
                data_b = ~b;
            end else begin
                start = 1'b0;
            end
            cycles++;
            if (cycles > done_timeout) begin
                $display("timeout: done did not rise within %0d cycles", done_timeout);
                $display("test failed");
                $fatal(1);
            end
            @(negedge clk);
        end
        start = 1'b0;

        check_data(result, exp_res, "result");
        check_count(cycles, exp_cycles, "busy_cycles");
        check_flag(busy, 1'b0, "busy");
        check_flag(done, 1'b1, "done");
    endtask

    initial begin
        logic [data_w-1:0] a;
        logic [data_w-1:0] b;

        seed   = 32'h8459423a;
        reset  = 1'b1;
        start  = 1'b0;
        data_a = '0;
        data_b = '0;

        repeat (8) @(negedge clk);
        reset = 1'b0;

        // state straight out of reset
        check_data(result, '0, "result");
        check_flag(busy, 1'b0, "busy");
        check_flag(done, 1'b0, "done");

        // a = 1 keeps r7 > r3 on every pass
        run_once(8'h01, 8'h55, 1'b0);

        // back to back from st_done with no reset in between
        for (int i = 0; i < num_runs; i++) begin
            a = $random(seed);
            b = $random(seed);
            run_once(a, b, (i % 4) == 1);
        end

        $display("test passed");
        $finish;
    end

endmodule

// File: files.f
+incdir+bench
rtl/seq_cpu_pkg.sv
rtl/alu.sv
rtl/register_file.sv
rtl/control_unit.sv
rtl/datapath.sv
rtl/seq_cpu_top.sv
bench/tb_seq_cpu.sv
